//--- Makefile
VERILATOR  ?= verilator
TOP        ?= tb_glitch_trigger
RTL_TOP    ?= glitch_trigger_top
FILELIST   ?= build.f
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "ALL CHECKS PASSED" $(LOG); then echo "simulation incomplete"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- build.f
source/glitch_cfg_pkg.sv
source/glitch_seq_pkg.sv
source/trig_capture.sv
source/glitch_sequencer.sv
source/glitch_pulse_gen.sv
source/glitch_trigger_top.sv
dv/tb_glitch_trigger.sv

//--- dv/tb_glitch_trigger.sv
`timescale 1ns/1ps

module tb_glitch_trigger;

  // cycles allowed for one whole glitch sequence
  localparam int wait_limit = 4000;

  logic clk;
  logic exttrig;
  logic trig_in;
  logic cfg_wr;
  logic cfg_addr;
  glitch_cfg_pkg::cfg_word_u cfg_data;
  logic glitch_out;
  logic [glitch_cfg_pkg::count_w-1:0] glitch_index;
  logic busy;
  logic done;

  glitch_trigger_top DUT (
    .clk          (clk),
    .exttrig      (exttrig),
    .trig_in      (trig_in),
    .cfg_wr       (cfg_wr),
    .cfg_addr     (cfg_addr),
    .cfg_data     (cfg_data),
    .glitch_out   (glitch_out),
    .glitch_index (glitch_index),
    .busy         (busy),
    .done         (done)
  );

  always #2 clk = ~clk;

  task automatic check_eq(input string name, input logic [31:0] act, input logic [31:0] exp);
    if (act !== exp) begin
      $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, act, exp);
      $display("CHECKS FAILED");
      $fatal(1);
    end
  endtask

  // one host write, called just after a rising edge
  task automatic write_cfg(input logic addr, input glitch_cfg_pkg::cfg_word_u word);
    cfg_wr   = 1'b1;
    cfg_addr = addr;
    cfg_data = word;
    @(posedge clk);
    #0.5;
    cfg_wr   = 1'b0;
    cfg_data = '0;
  endtask

  // trig_in level for each cycle of a run
  // the retrigger shape puts a second rising edge inside the first offset wait
  function automatic logic trigger_pattern(input int cyc, input bit retrig);
    if (retrig) begin
      return (cyc < 2) || (cyc >= 5 && cyc < 8);
    end
    return cyc < 2;
  endfunction

  // configure, trigger, then watch every cycle until done
  task automatic run_sequence(input int offset, input int num, input int width,
                              input bit hold, input bit retrig);
    glitch_cfg_pkg::cfg_word_u word;
    int cyc;
    int pulses;
    int last_rise;
    int hi_len;
    int held;
    bit prev_out;
    bit fin;
    cyc = 0;
    pulses = 0;
    last_rise = 0;
    hi_len = 0;
    held = 0;
    prev_out = 1'b0;
    fin = 1'b0;
    word = '0;
    word.offset = offset;
    write_cfg(glitch_cfg_pkg::cfg_addr_offset, word);
    word = '0;
    word.ctrl.num_glitches = num[glitch_cfg_pkg::count_w-1:0];
    word.ctrl.pulse_width  = width[glitch_cfg_pkg::width_w-1:0];
    write_cfg(glitch_cfg_pkg::cfg_addr_ctrl, word);
    trig_in = 1'b1;
    while (!fin) begin
      @(posedge clk);
      #0.5;
      cyc++;
      if (cyc > wait_limit) begin
        $display("timeout: sequence gave no done within %0d cycles", wait_limit);
        $display("CHECKS FAILED");
        $fatal(1);
      end
      if (glitch_out && !prev_out) begin
        // edge sampled in cycle 1, two sync stages and edge reg give start in cycle 3
        // fire comes offset+2 later and the pulse one cycle after that
        if (pulses == 0) begin
          check_eq("first glitch_out rise", cyc, offset + 6);
        end else begin
          check_eq("glitch_out rise spacing", cyc - last_rise, offset + 2);
        end
        check_eq("glitch_index", 32'(glitch_index), pulses);
        pulses++;
        last_rise = cyc;
        hi_len = 0;
      end
      if (glitch_out) begin
        hi_len++;
      end
      if (!glitch_out && prev_out) begin
        check_eq("glitch_out width", hi_len, width);
      end
      prev_out = glitch_out;
      if (done) begin
        check_eq("busy at done", 32'(busy), 0);
        check_eq("trig_in at done", 32'(trig_in), 0);
        check_eq("glitch count", pulses, num + 1);
        fin = 1'b1;
      end else begin
        // sequencer leaves idle the cycle after trig_start
        check_eq("busy", 32'(busy), 32'(cyc >= 4));
      end
      if (hold) begin
        // keep trig_in high for a while after the last pulse ended
        if (pulses == num + 1 && !glitch_out && trig_in) begin
          held++;
          if (held == 8) begin
            trig_in = 1'b0;
          end
        end
      end else begin
        trig_in = trigger_pattern(cyc, retrig);
      end
    end
    @(posedge clk);
    #0.5;
    check_eq("done after one cycle", 32'(done), 0);
    check_eq("busy after done", 32'(busy), 0);
  endtask

  task automatic test_reset_config();
    glitch_cfg_pkg::cfg_word_u word;
    check_eq("glitch_out after reset", 32'(glitch_out), 0);
    check_eq("busy after reset", 32'(busy), 0);
    check_eq("done after reset", 32'(done), 0);
    check_eq("glitch_index after reset", 32'(glitch_index), 0);
    word = '0;
    word.offset = 32'd20;
    write_cfg(glitch_cfg_pkg::cfg_addr_offset, word);
    word = '0;
    word.ctrl.num_glitches = 5'd3;
    word.ctrl.pulse_width  = 8'd6;
    write_cfg(glitch_cfg_pkg::cfg_addr_ctrl, word);
    // writes alone must not start anything
    repeat (10) begin
      @(posedge clk);
      #0.5;
      check_eq("glitch_out idle", 32'(glitch_out), 0);
      check_eq("busy idle", 32'(busy), 0);
      check_eq("done idle", 32'(done), 0);
    end
  endtask

  task automatic test_multi();
    int offset;
    int num;
    int width;
    offset = $urandom_range(30, 8);
    num = $urandom_range(6, 2);
    // widest legal pulse is offset+1
    width = $urandom_range(offset + 1, 1);
    run_sequence(offset, num, width, 1'b0, 1'b0);
  endtask

  initial begin
    void'($urandom(81890));
    clk      = 1'b0;
    exttrig  = 1'b1;
    trig_in  = 1'b0;
    cfg_wr   = 1'b0;
    cfg_addr = 1'b0;
    cfg_data = '0;
    repeat (3) @(posedge clk);
    #0.5;
    exttrig = 1'b0;
    test_reset_config();
    // single glitch
    run_sequence(10, 0, 4, 1'b0, 1'b0);
    test_multi();
    // trigger held past the last pulse
    run_sequence(9, 2, 3, 1'b1, 1'b0);
    // retrigger during the wait, then a fresh run
    run_sequence(12, 3, 5, 1'b0, 1'b1);
    run_sequence(8, 1, 9, 1'b0, 1'b0);
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

//--- source/glitch_cfg_pkg.sv
package glitch_cfg_pkg;

  // width of the trigger-to-glitch offset counter
  localparam int offset_w = 32;
  // glitch count and glitch index width
  localparam int count_w = 5;
  // pulse width field, in clk cycles
  localparam int width_w = 8;

  // host register map, one address bit
  localparam logic cfg_addr_offset = 1'b0;
  localparam logic cfg_addr_ctrl = 1'b1;

  // glitch control word as written by the host
  // num_glitches sits in the low bits, pulse width above it
  typedef struct packed {
    logic [31-count_w-width_w:0] spare;
    logic [width_w-1:0]          pulse_width;
    logic [count_w-1:0]          num_glitches;
  } glitch_ctrl_t;

  // one host word, read as offset or as control word
  // the write address picks the view
  typedef union packed {
    logic [offset_w-1:0] offset;
    glitch_ctrl_t        ctrl;
  } cfg_word_u;

  // live configuration shared by sequencer and pulse stage
  typedef struct packed {
    logic [offset_w-1:0] offset;
    logic [count_w-1:0]  num_glitches;
    logic [width_w-1:0]  pulse_width;
  } glitch_cfg_t;

endpackage

//--- source/glitch_pulse_gen.sv
`timescale 1ns/1ps

module glitch_pulse_gen (
  input  logic                                clk,
  input  logic                                exttrig,
  input  glitch_seq_pkg::fire_evt_t           evt,
  input  logic [glitch_cfg_pkg::width_w-1:0]  pulse_width,
  output logic                                glitch_out,
  output logic [glitch_cfg_pkg::count_w-1:0]  glitch_index,
  output logic                                pulse_end
);

  // cycles of glitch_out left, including the current one
  logic [glitch_cfg_pkg::width_w-1:0] width_cnt;
  // current cycle is the final high cycle of the pulse
  logic last;

  assign last = glitch_out && (width_cnt == 'd1);

  always_ff @(posedge clk or posedge exttrig) begin
    if (exttrig) begin
      width_cnt    <= '0;
      glitch_out   <= 1'b0;
      glitch_index <= '0;
    end else if (evt.fire) begin
      // load full width, output goes high next cycle
      width_cnt    <= pulse_width;
      glitch_out   <= 1'b1;
      glitch_index <= evt.index;
    end else if (width_cnt != '0) begin
      width_cnt  <= width_cnt - 1'b1;
      glitch_out <= !last;
    end
  end

  // flag the first low cycle after each pulse
  always_ff @(posedge clk or posedge exttrig) begin
    if (exttrig) begin
      pulse_end <= 1'b0;
    end else begin
      pulse_end <= last;
    end
  end

  // next fire must not land on a pulse still in progress
  a_no_overlap: assert property (
    @(posedge clk) disable iff (exttrig)
    evt.fire |-> !glitch_out
  );

endmodule

//--- source/glitch_seq_pkg.sv
package glitch_seq_pkg;

  // flops in the trig_in synchronizer chain
  localparam int sync_stages = 2;

  // sequencer states
  // s_wait counts the offset, s_next steps the index,
  // s_done waits for the last pulse and for trig_in low
  typedef enum logic [1:0] {
    s_idle = 2'd0,
    s_wait = 2'd1,
    s_next = 2'd2,
    s_done = 2'd3
  } seq_state_e;

  // one glitch request from the sequencer to the pulse stage
  typedef struct packed {
    logic                              fire;
    logic [glitch_cfg_pkg::count_w-1:0] index;
  } fire_evt_t;

endpackage

//--- source/glitch_sequencer.sv
`timescale 1ns/1ps

module glitch_sequencer (
  input  logic                        clk,
  input  logic                        exttrig,
  input  logic                        trig_start,
  input  logic                        trig_level,
  input  glitch_cfg_pkg::glitch_cfg_t cfg,
  input  logic                        pulse_end,
  output glitch_seq_pkg::fire_evt_t   evt,
  output logic                        busy,
  output logic                        done
);

  glitch_seq_pkg::seq_state_e state;

  // cycles spent in s_wait for the current glitch
  logic [glitch_cfg_pkg::offset_w-1:0] offset_cnt;
  // glitch currently being scheduled
  logic [glitch_cfg_pkg::count_w-1:0] index;
  // pulses finished so far, one bit wider to reach num_glitches+1
  logic [glitch_cfg_pkg::count_w:0] end_cnt;
  logic [glitch_cfg_pkg::count_w:0] total;
  // offset plus one, only for the width rule check
  logic [glitch_cfg_pkg::offset_w:0] offset_p1;
  logic match;
  logic all_ended;

  // offset reached while waiting
  assign match = (state == glitch_seq_pkg::s_wait) && (offset_cnt == cfg.offset);
  assign total = {1'b0, cfg.num_glitches} + 1'b1;
  assign all_ended = (end_cnt == total);
  assign offset_p1 = {1'b0, cfg.offset} + 1'b1;
  assign busy = (state != glitch_seq_pkg::s_idle);

  // counter restarts from zero on every entry into s_wait
  always_ff @(posedge clk or posedge exttrig) begin
    if (exttrig) begin
      offset_cnt <= '0;
    end else if (state == glitch_seq_pkg::s_wait) begin
      offset_cnt <= offset_cnt + 1'b1;
    end else begin
      offset_cnt <= '0;
    end
  end

  // fire strobe goes out one cycle after the match, with the index of that glitch
  always_ff @(posedge clk or posedge exttrig) begin
    if (exttrig) begin
      evt <= '0;
    end else begin
      evt.fire  <= match;
      evt.index <= index;
    end
  end

  // pulse ends are counted over the whole run
  // earlier pulses finish while later glitches are still being timed
  always_ff @(posedge clk or posedge exttrig) begin
    if (exttrig) begin
      end_cnt <= '0;
    end else if (state == glitch_seq_pkg::s_idle) begin
      end_cnt <= '0;
    end else if (pulse_end) begin
      end_cnt <= end_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk or posedge exttrig) begin
    if (exttrig) begin
      state <= glitch_seq_pkg::s_idle;
      index <= '0;
      done  <= 1'b0;
    end else begin
      // done is a single-cycle strobe
      done <= 1'b0;
      case (state)
        glitch_seq_pkg::s_idle: begin
          index <= '0;
          if (trig_start) begin
            state <= glitch_seq_pkg::s_wait;
          end
        end
        glitch_seq_pkg::s_wait: begin
          // retriggers are ignored here, only the offset matters
          if (match) begin
            if (index < cfg.num_glitches) begin
              state <= glitch_seq_pkg::s_next;
            end else begin
              state <= glitch_seq_pkg::s_done;
            end
          end
        end
        glitch_seq_pkg::s_next: begin
          index <= index + 1'b1;
          state <= glitch_seq_pkg::s_wait;
        end
        glitch_seq_pkg::s_done: begin
          // hold until every pulse is over and trigger has been released
          if (all_ended && !trig_level) begin
            state <= glitch_seq_pkg::s_idle;
            done  <= 1'b1;
          end
        end
        default: state <= glitch_seq_pkg::s_idle;
      endcase
    end
  end

  // fire only ever follows the s_wait cycle that ended the offset
  a_fire_after_match: assert property (
    @(posedge clk) disable iff (exttrig)
    evt.fire |-> ($past(state) == glitch_seq_pkg::s_wait) && (state != glitch_seq_pkg::s_wait)
  );

  // done is raised only once the sequencer is back in idle
  a_done_not_busy: assert property (
    @(posedge clk) disable iff (exttrig)
    done |-> !busy
  );

  // pulses may not overlap, so width fits inside one glitch period
  a_width_legal: assert property (
    @(posedge clk) disable iff (exttrig)
    (trig_start && !busy) |-> (cfg.pulse_width != '0) && (cfg.pulse_width <= offset_p1)
  );

endmodule

//--- source/glitch_trigger_top.sv
`timescale 1ns/1ps

module glitch_trigger_top (
  input  logic                               clk,
  input  logic                               exttrig,
  input  logic                               trig_in,
  input  logic                               cfg_wr,
  input  logic                               cfg_addr,
  input  glitch_cfg_pkg::cfg_word_u          cfg_data,
  output logic                               glitch_out,
  output logic [glitch_cfg_pkg::count_w-1:0] glitch_index,
  output logic                               busy,
  output logic                               done
);

  glitch_cfg_pkg::glitch_cfg_t cfg;
  glitch_seq_pkg::fire_evt_t   evt;
  logic                        trig_start;
  logic                        trig_level;
  logic                        pulse_end;

  // trigger synchronizer and host config registers
  trig_capture u_capture (
    .clk        (clk),
    .exttrig    (exttrig),
    .trig_in    (trig_in),
    .cfg_wr     (cfg_wr),
    .cfg_addr   (cfg_addr),
    .cfg_data   (cfg_data),
    .cfg        (cfg),
    .trig_start (trig_start),
    .trig_level (trig_level)
  );

  // offset timing and glitch repetition
  glitch_sequencer u_sequencer (
    .clk        (clk),
    .exttrig    (exttrig),
    .trig_start (trig_start),
    .trig_level (trig_level),
    .cfg        (cfg),
    .pulse_end  (pulse_end),
    .evt        (evt),
    .busy       (busy),
    .done       (done)
  );

  // strobe to pulse stretcher
  glitch_pulse_gen u_pulse_gen (
    .clk          (clk),
    .exttrig      (exttrig),
    .evt          (evt),
    .pulse_width  (cfg.pulse_width),
    .glitch_out   (glitch_out),
    .glitch_index (glitch_index),
    .pulse_end    (pulse_end)
  );

endmodule

//--- source/trig_capture.sv
`timescale 1ns/1ps

module trig_capture (
  input  logic                        clk,
  input  logic                        exttrig,
  input  logic                        trig_in,
  input  logic                        cfg_wr,
  input  logic                        cfg_addr,
  input  glitch_cfg_pkg::cfg_word_u   cfg_data,
  output glitch_cfg_pkg::glitch_cfg_t cfg,
  output logic                        trig_start,
  output logic                        trig_level
);

  // synchronizer chain, bit 0 samples the pin
  logic [glitch_seq_pkg::sync_stages-1:0] sync_q;
  // delayed synchronized level for the edge detector
  logic level_q;

  // last stage is the clean trigger level
  assign trig_level = sync_q[glitch_seq_pkg::sync_stages-1];

  always_ff @(posedge clk or posedge exttrig) begin
    if (exttrig) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[glitch_seq_pkg::sync_stages-2:0], trig_in};
    end
  end

  // rising edge, registered so trig_start is a clean one-cycle pulse
  always_ff @(posedge clk or posedge exttrig) begin
    if (exttrig) begin
      level_q    <= 1'b0;
      trig_start <= 1'b0;
    end else begin
      level_q    <= trig_level;
      trig_start <= trig_level & ~level_q;
    end
  end

  // config registers
  // offset address takes the whole word, ctrl address splits count and width
  always_ff @(posedge clk or posedge exttrig) begin
    if (exttrig) begin
      cfg <= '0;
    end else if (cfg_wr) begin
      if (cfg_addr == glitch_cfg_pkg::cfg_addr_offset) begin
        cfg.offset <= cfg_data.offset;
      end else begin
        cfg.num_glitches <= cfg_data.ctrl.num_glitches;
        cfg.pulse_width  <= cfg_data.ctrl.pulse_width;
      end
    end
  end

  // edge detector must never produce a stretched start pulse
  a_start_single: assert property (
    @(posedge clk) disable iff (exttrig)
    trig_start |=> !trig_start
  );

endmodule
